//--- all.f
+incdir+bench
hdl/sboxPkg.sv
hdl/maskRandIf.sv
hdl/linMap.sv
hdl/domMulGf4.sv
hdl/domSqScMulGf4.sv
hdl/domInvGf4.sv
hdl/maskedSbox.sv
hdl/maskPrng.sv
hdl/maskedSboxTop.sv
bench/maskedSboxTb.sv

//--- Bender.yml
package:
  name: masked_sbox

sources:
  # Design, in compile order
  - hdl/sboxPkg.sv
  - hdl/maskRandIf.sv
  - hdl/linMap.sv
  - hdl/domMulGf4.sv
  - hdl/domSqScMulGf4.sv
  - hdl/domInvGf4.sv
  - hdl/maskedSbox.sv
  - hdl/maskPrng.sv
  - hdl/maskedSboxTop.sv

  # Testbench
  - target: test
    include_dirs:
      - bench
    files:
      - bench/maskedSboxTb.sv

//--- bench/sboxRef.svh
`ifndef SBOX_REF_SVH
`define SBOX_REF_SVH

// AES field multiply, Horner over the bits of b
function automatic logic [7:0] gf8Mult(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    p = '0;
    for (int i = 7; i >= 0; i--) begin
        // Double, reduce by 0x11B
        p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1B : 8'h00);
        if (b[i]) begin
            p = p ^ a;
        end
    end
    return p;
endfunction

// a^254 by square and multiply, zero stays zero
function automatic logic [7:0] gf8Inverse(input logic [7:0] a);
    logic [7:0] r;
    r = 8'h01;
    for (int i = 7; i >= 0; i--) begin
        r = gf8Mult(r, r);
        // Exponent 254 = 1111_1110
        if (i != 0) begin
            r = gf8Mult(r, a);
        end
    end
    return r;
endfunction

// Inversion, then the FIPS-197 affine step
function automatic logic [7:0] sboxCalc(input logic [7:0] x);
    logic [7:0] b;
    b = gf8Inverse(x);
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
           ^ {b[3:0], b[7:4]} ^ 8'h63;
endfunction

// 32-bit Galois LFSR, shifts right, maximal tap mask
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'hB4BC_D35C : 32'h0);
endfunction

`endif

//--- bench/maskedSboxTb.sv
`timescale 1ns/1ps
`default_nettype none

module maskedSboxTb;
    `include "sboxRef.svh"

    localparam int numShares = 2;
    localparam int period = 100;
    // Drive edge to result, counted in clock edges
    localparam int pipeDepth = 4;
    localparam int resetCycles = 4;
    localparam int knownCount = 3;
    localparam int burstLen = 64;
    localparam int randCount = 2000;
    localparam int maxGap = 2;
    // Worst case stimulus length plus drain and margin
    localparam int watchdogCycles = resetCycles + 1 + knownCount + burstLen
                                    + randCount * (1 + maxGap) + pipeDepth + 20;

    logic                   ClkxCI;
    logic                   reset;
    logic                   inValid;
    logic [8*numShares-1:0] xShares;
    logic                   outValid;
    logic [8*numShares-1:0] qShares;

    logic [31:0] rngState;
    logic [7:0]  sboxTable [256];
    // Model queue, unmasked byte and its drive time
    logic [7:0]  expByte [$];
    time         expTime [$];
    logic        resetDly;
    int          errCnt;
    int          checkCnt;
    int          resultCnt;

    maskedSboxTop #(.SHARES(numShares)) dut (
        .ClkxCI(ClkxCI),
        .reset(reset),
        .inValid(inValid),
        .xShares(xShares),
        .outValid(outValid),
        .qShares(qShares)
    );

    always #(period/2) ClkxCI = ~ClkxCI;

    // One LFSR step per bit, newest bit at the LSB, up to 8 bits
    function automatic logic [7:0] takeBits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            rngState = lfsrNext(rngState);
            r = {r[6:0], rngState[0]};
        end
        return r;
    endfunction

    // XOR of all byte shares
    function automatic logic [7:0] unmask(input logic [8*numShares-1:0] v);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < numShares; i++) begin
            r = r ^ v[8*i +: 8];
        end
        return r;
    endfunction

    // Valid byte for one cycle, share 0 closes the sum
    task automatic sendByte(input logic [7:0] b, input logic zeroMask);
        logic [8*numShares-1:0] v;
        logic [7:0] s0;
        v = '0;
        s0 = b;
        for (int i = 1; i < numShares; i++) begin
            if (!zeroMask) begin
                v[8*i +: 8] = takeBits(8);
            end
            s0 = s0 ^ v[8*i +: 8];
        end
        v[7:0] = s0;
        @(posedge ClkxCI);
        inValid <= 1'b1;
        xShares <= v;
        expByte.push_back(b);
        expTime.push_back($time);
    endtask

    // Valid low, junk on the data lines
    task automatic idleCycle();
        logic [8*numShares-1:0] junk;
        for (int i = 0; i < numShares; i++) begin
            junk[8*i +: 8] = takeBits(8);
        end
        @(posedge ClkxCI);
        inValid <= 1'b0;
        xShares <= junk;
    endtask

    // Output checks away from the driving edge
    always @(negedge ClkxCI) begin
        logic [7:0] gotByte;
        logic [7:0] wantByte;
        time due;
        due = 0;
        if (expByte.size() > 0) begin
            due = expTime[0] + pipeDepth * period + period / 2;
        end
        if (reset || resetDly) begin
            // In reset and one cycle after
            checkCnt++;
            if (outValid !== 1'b0) begin
                errCnt++;
                $display("FAIL t=%0t outValid got %b exp 0", $time, outValid);
            end
        end else if (outValid !== 1'b0 && outValid !== 1'b1) begin
            errCnt++;
            $display("Error at %0t: outValid is unknown", $time);
        end else if (outValid) begin
            if (expByte.size() == 0) begin
                errCnt++;
                $display("Error at %0t: outValid high with no byte in flight", $time);
            end else begin
                checkCnt++;
                if ($time != due) begin
                    errCnt++;
                    $display("FAIL t=%0t outValid arrival got %0t exp %0t", $time, $time, due);
                end
                gotByte = unmask(qShares);
                wantByte = sboxTable[expByte[0]];
                if (gotByte !== wantByte) begin
                    errCnt++;
                    $display("FAIL t=%0t qShares got %02h exp %02h (in %02h)",
                             $time, gotByte, wantByte, expByte[0]);
                end
                void'(expByte.pop_front());
                void'(expTime.pop_front());
                resultCnt++;
            end
        end else if (expByte.size() > 0 && $time >= due) begin
            // Gap where a result was due
            errCnt++;
            $display("FAIL t=%0t outValid got 0 exp 1 (in %02h)", $time, expByte[0]);
            void'(expByte.pop_front());
            void'(expTime.pop_front());
        end
        resetDly = reset;
    end

    initial begin
        logic [7:0] b;
        int gap;
        ClkxCI = 1'b0;
        reset = 1'b1;
        // Strobe high through reset, the valid line must still come out clear
        inValid = 1'b1;
        xShares = '0;
        rngState = 32'd83927;
        resetDly = 1'b1;
        errCnt = 0;
        checkCnt = 0;
        resultCnt = 0;
        for (int i = 0; i < 256; i++) begin
            sboxTable[i] = sboxCalc(i[7:0]);
        end
        // Model against known FIPS-197 entries
        if (sboxTable[8'h00] !== 8'h63 || sboxTable[8'h01] !== 8'h7C
            || sboxTable[8'h53] !== 8'hED) begin
            errCnt++;
            $display("Error: reference S-box disagrees with the known AES entries");
        end

        repeat (resetCycles) @(posedge ClkxCI);
        reset <= 1'b0;
        inValid <= 1'b0;
        // First cycle out of reset, nothing sent
        idleCycle();

        // Known values, first one with all-zero shares
        sendByte(8'h00, 1'b1);
        sendByte(8'h01, 1'b0);
        sendByte(8'h53, 1'b0);

        // Back-to-back burst
        for (int n = 0; n < burstLen; n++) begin
            b = takeBits(8);
            sendByte(b, 1'b0);
        end

        // Random bytes with random gaps of 1 or 2 cycles
        for (int n = 0; n < randCount; n++) begin
            if (takeBits(2) == 0) begin
                gap = takeBits(1) + 1;
                repeat (gap) idleCycle();
            end
            b = takeBits(8);
            sendByte(b, 1'b0);
        end

        // Drain, then a quiet tail
        repeat (pipeDepth + 4) idleCycle();
        if (expByte.size() != 0) begin
            errCnt++;
            $display("Error: %0d results never came out", expByte.size());
        end
        if (resultCnt != knownCount + burstLen + randCount) begin
            errCnt++;
            $display("Error: %0d results seen, %0d bytes sent",
                     resultCnt, knownCount + burstLen + randCount);
        end

        $display("Checks: %0d, results: %0d, errors: %0d", checkCnt, resultCnt, errCnt);
        if (errCnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Stops a stuck run
    initial begin
        #(watchdogCycles * period);
        $display("Error: watchdog expired after %0d cycles, run stopped", watchdogCycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/maskedSboxTop.sv
`timescale 1ns/1ps
`default_nettype none

module maskedSboxTop #(
    parameter int SHARES = sboxPkg::defaultShares,
    parameter logic [sboxPkg::zBitsTotal(SHARES)-1:0] PRNG_SEED = 'hACE1
) (
    input  logic                 ClkxCI,
    input  logic                 reset,
    input  logic                 inValid,
    input  logic [8*SHARES-1:0]  xShares,
    output logic                 outValid,
    output logic [8*SHARES-1:0]  qShares
);
    // Fresh masks, new value every cycle
    maskRandIf #(.SHARES(SHARES)) rndBus ();

    maskPrng #(.SHARES(SHARES), .SEED(PRNG_SEED)) prng (
        .ClkxCI(ClkxCI),
        .reset(reset),
        .rnd(rndBus.source)
    );

    // Four-stage shared S-box
    maskedSbox #(.SHARES(SHARES)) sbox (
        .ClkxCI(ClkxCI),
        .reset(reset),
        .inValid(inValid),
        .xShares(xShares),
        .rnd(rndBus.sink),
        .outValid(outValid),
        .qShares(qShares)
    );

endmodule

`default_nettype wire

//--- hdl/maskPrng.sv
`timescale 1ns/1ps
`default_nettype none

module maskPrng #(
    parameter int SHARES = sboxPkg::defaultShares,
    parameter logic [sboxPkg::zBitsTotal(SHARES)-1:0] SEED = '1
) (
    input  logic      ClkxCI,
    input  logic      reset,
    maskRandIf.source rnd
);
    import sboxPkg::*;

    localparam int W = zBitsTotal(SHARES);
    localparam int ZW = zBitsGf4(SHARES);
    // Top tap keeps the step invertible, 0xB400 at 16 bits
    localparam logic [W-1:0] TAPS = (W'(1) << (W - 1)) | (W'(1) << (W - 3))
                                  | (W'(1) << (W - 4)) | (W'(1) << (W - 6));

    logic [W-1:0] lfsrState;

    // Galois form, shift right
    always_ff @(posedge ClkxCI) begin
        if (reset) begin
            lfsrState <= SEED;
        end else begin
            lfsrState <= (lfsrState >> 1) ^ (lfsrState[0] ? TAPS : '0);
        end
    end

    // One slice per DOM unit
    assign rnd.zSqSc  = lfsrState[0*ZW +: ZW];
    assign rnd.zInv   = lfsrState[1*ZW +: ZW];
    assign rnd.zMulHi = lfsrState[2*ZW +: ZW];
    assign rnd.zMulLo = lfsrState[3*ZW +: ZW];

    // Stuck at zero would leave the S-box unmasked
    assert property (@(posedge ClkxCI) disable iff (reset) lfsrState != '0);

endmodule

`default_nettype wire

//--- hdl/maskedSbox.sv
`timescale 1ns/1ps
`default_nettype none

module maskedSbox #(
    parameter int SHARES = sboxPkg::defaultShares
) (
    input  logic                  ClkxCI,
    input  logic                  reset,
    input  logic                  inValid,
    input  logic [8*SHARES-1:0]   xShares,
    maskRandIf.sink               rnd,
    output logic                  outValid,
    output logic [8*SHARES-1:0]   qShares
);
    import sboxPkg::*;

    logic [7:0] mapped [SHARES];
    logic [7:0] mappedQ [SHARES];
    logic [7:0] invByte [SHARES];
    logic [7:0] outByte [SHARES];

    // Nibble vectors, share i at [4i+:4]
    logic [4*SHARES-1:0] y1;
    logic [4*SHARES-1:0] y0;
    logic [4*SHARES-1:0] y1D1;
    logic [4*SHARES-1:0] y0D1;
    logic [4*SHARES-1:0] y1D2;
    logic [4*SHARES-1:0] y0D2;
    logic [4*SHARES-1:0] delta;
    logic [4*SHARES-1:0] deltaInv;
    logic [4*SHARES-1:0] invHi;
    logic [4*SHARES-1:0] invLo;

    logic [sboxLatency-1:0] validSr;

    for (genvar i = 0; i < SHARES; i++) begin : gShare
        // Into the tower field
        linMap #(.MATRIX_SEL(1)) inMap (
            .dataIn(xShares[8*i +: 8]),
            .dataOut(mapped[i])
        );

        assign y1[4*i +: 4] = mappedQ[i][7:4];
        assign y0[4*i +: 4] = mappedQ[i][3:0];

        // Inverse is (Y1/D) y + (Y0+Y1)/D
        assign invByte[i] = {invHi[4*i +: 4], invLo[4*i +: 4]};

        // Back to AES basis with the affine matrix
        linMap #(.MATRIX_SEL(0)) outMap (
            .dataIn(invByte[i]),
            .dataOut(outByte[i])
        );

        // Constant only once
        if (i == 0) begin : gConst
            assign qShares[7:0] = outByte[0] ^ 8'h63;
        end else begin : gPlain
            assign qShares[8*i +: 8] = outByte[i];
        end
    end

    // Stage 1, input register
    always_ff @(posedge ClkxCI) begin
        mappedQ <= mapped;
    end

    // Halves wait two stages for the inverse
    always_ff @(posedge ClkxCI) begin
        y1D1 <= y1;
        y0D1 <= y0;
        y1D2 <= y1D1;
        y0D2 <= y0D1;
    end

    // Stage 2, norm
    domSqScMulGf4 #(.SHARES(SHARES)) sqScMul (
        .ClkxCI(ClkxCI),
        .aShares(y1),
        .bShares(y0),
        .z(rnd.zSqSc),
        .qShares(delta)
    );

    // Stage 3, nibble inverse
    domInvGf4 #(.SHARES(SHARES)) inv (
        .ClkxCI(ClkxCI),
        .aShares(delta),
        .z(rnd.zInv),
        .qShares(deltaInv)
    );

    // Stage 4, both halves of the result
    domMulGf4 #(.SHARES(SHARES)) mulHi (
        .ClkxCI(ClkxCI),
        .aShares(deltaInv),
        .bShares(y1D2),
        .z(rnd.zMulHi),
        .qShares(invHi)
    );

    domMulGf4 #(.SHARES(SHARES)) mulLo (
        .ClkxCI(ClkxCI),
        .aShares(deltaInv),
        .bShares(y0D2 ^ y1D2),
        .z(rnd.zMulLo),
        .qShares(invLo)
    );

    // Valid strobe follows the data
    always_ff @(posedge ClkxCI) begin
        if (reset) begin
            validSr <= '0;
        end else begin
            validSr <= {validSr[sboxLatency-2:0], inValid};
        end
    end

    assign outValid = validSr[sboxLatency-1];

    // Strobe stays defined, needs inValid driven cleanly from outside
    assert property (@(posedge ClkxCI) disable iff (reset) !$isunknown(outValid));

endmodule

`default_nettype wire

//--- hdl/domInvGf4.sv
`timescale 1ns/1ps
`default_nettype none

module domInvGf4 #(
    parameter int SHARES = sboxPkg::defaultShares
) (
    input  logic                                  ClkxCI,
    input  logic [4*SHARES-1:0]                   aShares,
    input  logic [sboxPkg::zBitsGf4(SHARES)-1:0]  z,
    output logic [4*SHARES-1:0]                   qShares
);
    import sboxPkg::*;

    logic [3:0] innerD [SHARES];
    logic [3:0] innerQ [SHARES];
    // Entry j-1 belongs to share j
    logic [3:0] crossD [SHARES-1];
    logic [3:0] crossQ [SHARES-1];
    logic [3:0] maskQ [SHARES-1];

    // Share j joins the running sum of shares below it
    always_comb begin
        logic [3:0] prefix;
        logic [3:0] nextPrefix;
        prefix = aShares[3:0];
        for (int i = 0; i < SHARES; i++) begin
            innerD[i] = gf4Inv(aShares[4*i +: 4]);
        end
        for (int j = 1; j < SHARES; j++) begin
            nextPrefix = prefix ^ aShares[4*j +: 4];
            // Correction term, masked before the register
            crossD[j-1] = gf4Inv(nextPrefix) ^ gf4Inv(prefix) ^ innerD[j]
                          ^ z[4*(j-1) +: 4];
            prefix = nextPrefix;
        end
    end

    always_ff @(posedge ClkxCI) begin
        innerQ <= innerD;
        crossQ <= crossD;
        for (int j = 0; j < SHARES - 1; j++) begin
            maskQ[j] <= z[4*j +: 4];
        end
    end

    always_comb begin
        for (int i = 0; i < SHARES; i++) begin
            qShares[4*i +: 4] = innerQ[i];
        end
        // Mask j lands in domains j and j-1, so it cancels in the sum
        for (int j = 1; j < SHARES; j++) begin
            qShares[4*j +: 4] = qShares[4*j +: 4] ^ crossQ[j-1];
            qShares[4*(j-1) +: 4] = qShares[4*(j-1) +: 4] ^ maskQ[j-1];
        end
    end

endmodule

`default_nettype wire

//--- hdl/domSqScMulGf4.sv
`timescale 1ns/1ps
`default_nettype none

module domSqScMulGf4 #(
    parameter int SHARES = sboxPkg::defaultShares
) (
    input  logic                                  ClkxCI,
    input  logic [4*SHARES-1:0]                   aShares,
    input  logic [4*SHARES-1:0]                   bShares,
    input  logic [sboxPkg::zBitsGf4(SHARES)-1:0]  z,
    output logic [4*SHARES-1:0]                   qShares
);
    import sboxPkg::*;

    // Norm = lambda*a^2 + a*b + b^2, a = Y1, b = Y0
    logic [3:0] termD [SHARES][SHARES];
    logic [3:0] termQ [SHARES][SHARES];

    always_comb begin
        for (int i = 0; i < SHARES; i++) begin
            for (int j = 0; j < SHARES; j++) begin
                if (i == j) begin
                    // Squares are linear, stay inside the domain
                    termD[i][j] = gf4SqSc(aShares[4*i +: 4])
                                  ^ gf4Mul(aShares[4*i +: 4], bShares[4*i +: 4])
                                  ^ gf4Mul(bShares[4*i +: 4], bShares[4*i +: 4]);
                end else begin
                    termD[i][j] = gf4Mul(aShares[4*i +: 4], bShares[4*j +: 4])
                                  ^ z[4*pairIdx(SHARES, i, j) +: 4];
                end
            end
        end
    end

    always_ff @(posedge ClkxCI) begin
        termQ <= termD;
    end

    always_comb begin
        for (int i = 0; i < SHARES; i++) begin
            qShares[4*i +: 4] = '0;
            for (int j = 0; j < SHARES; j++) begin
                qShares[4*i +: 4] = qShares[4*i +: 4] ^ termQ[i][j];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/domMulGf4.sv
`timescale 1ns/1ps
`default_nettype none

module domMulGf4 #(
    parameter int SHARES = sboxPkg::defaultShares
) (
    input  logic                                  ClkxCI,
    input  logic [4*SHARES-1:0]                   aShares,
    input  logic [4*SHARES-1:0]                   bShares,
    input  logic [sboxPkg::zBitsGf4(SHARES)-1:0]  z,
    output logic [4*SHARES-1:0]                   qShares
);
    import sboxPkg::*;

    logic [3:0] termD [SHARES][SHARES];
    logic [3:0] termQ [SHARES][SHARES];

    always_comb begin
        for (int i = 0; i < SHARES; i++) begin
            for (int j = 0; j < SHARES; j++) begin
                if (i == j) begin
                    // Inner domain
                    termD[i][j] = gf4Mul(aShares[4*i +: 4], bShares[4*j +: 4]);
                end else begin
                    // Cross domain, same mask on both sides of a pair
                    termD[i][j] = gf4Mul(aShares[4*i +: 4], bShares[4*j +: 4])
                                  ^ z[4*pairIdx(SHARES, i, j) +: 4];
                end
            end
        end
    end

    // Register before compression
    always_ff @(posedge ClkxCI) begin
        termQ <= termD;
    end

    // Compress per domain
    always_comb begin
        for (int i = 0; i < SHARES; i++) begin
            qShares[4*i +: 4] = '0;
            for (int j = 0; j < SHARES; j++) begin
                qShares[4*i +: 4] = qShares[4*i +: 4] ^ termQ[i][j];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/linMap.sv
`timescale 1ns/1ps
`default_nettype none

module linMap #(
    parameter int MATRIX_SEL = 1
) (
    input  logic [7:0] dataIn,
    output logic [7:0] dataOut
);
    // AES field multiply, poly 0x11B
    function automatic logic [7:0] gf8Mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] t;
        p = '0;
        t = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ t;
            end
            t = {t[6:0], 1'b0} ^ (t[7] ? 8'h1B : 8'h00);
        end
        return p;
    endfunction

    // Matrix as eight columns, column j at bits [8j+:8]
    function automatic logic [7:0] applyCols(input logic [63:0] m, input logic [7:0] v);
        logic [7:0] r;
        r = '0;
        for (int j = 0; j < 8; j++) begin
            if (v[j]) begin
                r = r ^ m[8*j +: 8];
            end
        end
        return r;
    endfunction

    // Tower basis images: x^k and y*x^k
    function automatic logic [63:0] towerCols();
        logic [7:0] beta;
        logic [7:0] gamma;
        logic [7:0] pw;
        logic [63:0] m;
        beta = '0;
        gamma = '0;
        // Root of x^4 + x + 1 inside the AES field
        for (int c = 2; c < 256; c++) begin
            pw = gf8Mul(c[7:0], c[7:0]);
            pw = gf8Mul(pw, pw);
            if (beta == '0 && (pw ^ c[7:0]) == 8'h01) begin
                beta = c[7:0];
            end
        end
        // Powers of beta
        m[7:0] = 8'h01;
        for (int k = 1; k < 4; k++) begin
            m[8*k +: 8] = gf8Mul(m[8*(k-1) +: 8], beta);
        end
        // Root of y^2 + y + lambda, lambda image is beta^3
        for (int c = 2; c < 256; c++) begin
            pw = gf8Mul(c[7:0], c[7:0]) ^ c[7:0] ^ m[31:24];
            if (gamma == '0 && pw == '0) begin
                gamma = c[7:0];
            end
        end
        for (int k = 0; k < 4; k++) begin
            m[8*(k+4) +: 8] = gf8Mul(gamma, m[8*k +: 8]);
        end
        return m;
    endfunction

    function automatic logic [63:0] mapCols();
        logic [63:0] t;
        logic [63:0] m;
        logic [7:0] a;
        t = towerCols();
        m = '0;
        for (int j = 0; j < 8; j++) begin
            if (MATRIX_SEL == 1) begin
                // Invert by search over the basis images
                for (int v = 0; v < 256; v++) begin
                    if (applyCols(t, v[7:0]) == (8'h01 << j)) begin
                        m[8*j +: 8] = v[7:0];
                    end
                end
            end else begin
                // AES affine matrix on top, constant added outside
                a = t[8*j +: 8];
                for (int i = 0; i < 8; i++) begin
                    m[8*j + i] = a[i] ^ a[(i+4)%8] ^ a[(i+5)%8] ^ a[(i+6)%8] ^ a[(i+7)%8];
                end
            end
        end
        return m;
    endfunction

    localparam logic [63:0] COLS = mapCols();

    // Constant matrix, reduces to XOR trees
    assign dataOut = applyCols(COLS, dataIn);

endmodule

`default_nettype wire

//--- hdl/maskRandIf.sv
`timescale 1ns/1ps
`default_nettype none

interface maskRandIf #(
    parameter int SHARES = sboxPkg::defaultShares
);
    import sboxPkg::*;

    localparam int ZW = zBitsGf4(SHARES);

    // Masks for the norm stage
    logic [ZW-1:0] zSqSc;
    // Masks for the nibble inverter
    logic [ZW-1:0] zInv;
    // Masks for the two output multipliers
    logic [ZW-1:0] zMulHi;
    logic [ZW-1:0] zMulLo;

    // Generator side
    modport source (
        output zSqSc,
        output zInv,
        output zMulHi,
        output zMulLo
    );

    // S-box side
    modport sink (
        input zSqSc,
        input zInv,
        input zMulHi,
        input zMulLo
    );

endinterface

`default_nettype wire

//--- hdl/sboxPkg.sv
`default_nettype none

package sboxPkg;

    // Two shares gives first-order protection
    parameter int defaultShares = 2;

    // Input map, square-scale, inverter, multipliers
    parameter int sboxLatency = 4;

    // Four fresh bits per unordered pair of shares
    function automatic int zBitsGf4(input int shares);
        return 2 * shares * (shares - 1);
    endfunction

    // Four GF(2^4) units per S-box
    function automatic int zBitsTotal(input int shares);
        return 4 * zBitsGf4(shares);
    endfunction

    // Index of the unordered pair (i, j), i != j
    function automatic int pairIdx(input int shares, input int i, input int j);
        int lo;
        int hi;
        lo = (i < j) ? i : j;
        hi = (i < j) ? j : i;
        return lo * shares - (lo * (lo + 1)) / 2 + (hi - lo - 1);
    endfunction

    // Polynomial basis, field poly x^4 + x + 1
    function automatic logic [3:0] gf4Mul(input logic [3:0] a, input logic [3:0] b);
        logic [3:0] p;
        logic [3:0] t;
        p = '0;
        t = a;
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                p = p ^ t;
            end
            t = {t[2:0], 1'b0} ^ (t[3] ? 4'h3 : 4'h0);
        end
        return p;
    endfunction

    // Square, then scale by lambda = x^3 (trace 1, so y^2+y+lambda is irreducible)
    function automatic logic [3:0] gf4SqSc(input logic [3:0] a);
        return gf4Mul(4'h8, gf4Mul(a, a));
    endfunction

    // Zero maps to zero
    function automatic logic [3:0] gf4Inv(input logic [3:0] a);
        logic [3:0] r;
        r = '0;
        for (int c = 1; c < 16; c++) begin
            if (gf4Mul(a, c[3:0]) == 4'h1) begin
                r = c[3:0];
            end
        end
        return r;
    endfunction

endpackage

`default_nettype wire
